/* tb.f */
hdl/fir_pkg.sv
hdl/tap_delay_line.sv
hdl/coef_regfile_axil.sv
hdl/mac_sequencer.sv
hdl/fir_filter_top.sv
bench/fir_checker.sv
bench/fir_filter_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = fir_filter_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* bench/fir_filter_tb.sv */
`timescale 1ns/1ps

module fir_filter_tb;

	import fir_pkg::*;

	localparam int DATA_WIDTH = 16;
	localparam int COEF_WIDTH = 16;
	localparam int NUM_TAPS   = 8;
	localparam int WAIT_LIMIT = 50;

	typedef enum
	{
		OP_WR_COEF,
		OP_WR_SHIFT,
		OP_BAD_WR,
		OP_RD_COEF,
		OP_SEND,
		OP_SEND_RAND,
		OP_STALL
	} op_t;

	logic                         clk;
	logic                         reset;
	logic [DATA_WIDTH-1:0]        in_data;
	logic                         in_valid;
	logic                         in_ready;
	logic [OUT_WIDTH-1:0]         out_data;
	logic                         out_valid;
	logic                         out_ready;
	logic [AXIL_ADDR_WIDTH-1:0]   awaddr;
	logic                         awvalid;
	logic                         awready;
	logic [AXIL_DATA_WIDTH-1:0]   wdata;
	logic [AXIL_DATA_WIDTH/8-1:0] wstrb;
	logic                         wvalid;
	logic                         wready;
	axil_resp_t                   bresp;
	logic                         bvalid;
	logic                         bready;
	logic [AXIL_ADDR_WIDTH-1:0]   araddr;
	logic                         arvalid;
	logic                         arready;
	logic [AXIL_DATA_WIDTH-1:0]   rdata;
	axil_resp_t                   rresp;
	logic                         rvalid;
	logic                         rready;

	// counts kept by the checker
	int error_count;
	int result_count;

	// stimulus table, one entry per test
	string       names [$];
	op_t         ops [$];
	int          addrs [$];
	logic [31:0] datas [$];
	int          counts [$];
	logic [31:0] exp_vals [$];

	logic [31:0] rng_state = 32'd67;
	logic [15:0] rand_coefs [NUM_TAPS];
	string       cur_name = "reset";
	int          tb_errors = 0;
	int          sent_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          errs_before;
	bit          timed_out = 0;

	fir_filter_top #(
		.DATA_WIDTH (DATA_WIDTH),
		.COEF_WIDTH (COEF_WIDTH),
		.NUM_TAPS   (NUM_TAPS)
	) fir_filter_top_inst (.*);

	fir_checker #(
		.DATA_WIDTH (DATA_WIDTH),
		.COEF_WIDTH (COEF_WIDTH),
		.NUM_TAPS   (NUM_TAPS)
	) fir_checker_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic void add_row(input string name, input op_t op, input int addr,
		input logic [31:0] data, input int count, input logic [31:0] exp_val);
		names.push_back(name);
		ops.push_back(op);
		addrs.push_back(addr);
		datas.push_back(data);
		counts.push_back(count);
		exp_vals.push_back(exp_val);
	endfunction

	function automatic void check_value(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val)
		begin
			$display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp_val, act_val);
			tb_errors++;
		end
	endfunction

	function automatic void report_timeout(input string what);
		$display("Timeout in %s: no %s within %0d cycles", cur_name, what, WAIT_LIMIT);
		tb_errors++;
		timed_out = 1;
	endfunction

	// ==================================================
	// bus and stream tasks
	// ==================================================
	task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
		output axil_resp_t resp);
		int waited;
		bit aw_done;
		bit w_done;
		resp = RESP_SLVERR;
		if (timed_out)
			return;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= '1;
		wvalid  <= 1'b1;
		bready  <= 1'b0;
		aw_done = 0;
		w_done = 0;
		waited = 0;
		while (!(aw_done && w_done) && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
			if (!aw_done && awready)
			begin
				aw_done = 1;
				awvalid <= 1'b0;
			end
			if (!w_done && wready)
			begin
				w_done = 1;
				wvalid <= 1'b0;
			end
		end
		if (!(aw_done && w_done))
		begin
			report_timeout("write address and data handshake");
			return;
		end
		waited = 0;
		@(posedge clk);
		while (!bvalid && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (!bvalid)
			report_timeout("write response");
		else
		begin
			// response waits one cycle before it is taken
			resp = bresp;
			bready <= 1'b1;
			@(posedge clk);
		end
	endtask

	task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
		output axil_resp_t resp);
		int waited;
		data = '0;
		resp = RESP_SLVERR;
		if (timed_out)
			return;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b0;
		waited = 0;
		@(posedge clk);
		while (!arready && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		arvalid <= 1'b0;
		if (!arready)
		begin
			report_timeout("read address handshake");
			return;
		end
		waited = 0;
		@(posedge clk);
		while (!rvalid && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (!rvalid)
			report_timeout("read data");
		else
		begin
			data = rdata;
			resp = rresp;
			rready <= 1'b1;
			@(posedge clk);
		end
	endtask

	// one sample in, its result out; stall holds out_ready low that many cycles
	task automatic send_sample(input logic [DATA_WIDTH-1:0] value, input int stall);
		int waited;
		if (timed_out)
			return;
		@(posedge clk);
		in_data   <= value;
		in_valid  <= 1'b1;
		out_ready <= (stall == 0);
		waited = 0;
		@(posedge clk);
		while (!in_ready && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		in_valid <= 1'b0;
		if (!in_ready)
		begin
			report_timeout("input handshake");
			return;
		end
		sent_count++;
		waited = 0;
		@(posedge clk);
		while (!out_valid && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (!out_valid)
		begin
			report_timeout("result");
			return;
		end
		if (stall > 0)
		begin
			repeat (stall) @(posedge clk);
			out_ready <= 1'b1;
			@(posedge clk);
		end
	endtask

	// ==================================================
	// stimulus table
	// ==================================================
	task automatic build_table();
		logic [31:0] r;
		add_row("rd_after_reset", OP_RD_COEF, 3, 0, 0, 32'h0);
		add_row("shift_zero", OP_WR_SHIFT, 0, 0, 0, 0);
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			r = next_random();
			rand_coefs[i] = r[15:0];
			add_row($sformatf("wr_coef_%0d", i), OP_WR_COEF, i, 32'(rand_coefs[i]), 0, 0);
		end
		for (int i = 0; i < NUM_TAPS; i++)
			add_row($sformatf("rd_coef_%0d", i), OP_RD_COEF, i, 0, 0,
				{{16{rand_coefs[i][15]}}, rand_coefs[i]});
		// taps are still zero from reset, so this covers the fill phase
		add_row("fill_random", OP_SEND_RAND, 0, 0, 24, 0);
		add_row("bad_unmapped", OP_BAD_WR, 12'h040, 32'h7fff, 0, 0);
		add_row("bad_unaligned", OP_BAD_WR, 12'h006, 32'h5555, 0, 0);
		add_row("rd_after_bad_0", OP_RD_COEF, 0, 0, 0, {{16{rand_coefs[0][15]}}, rand_coefs[0]});
		add_row("rd_after_bad", OP_RD_COEF, 1, 0, 0, {{16{rand_coefs[1][15]}}, rand_coefs[1]});
		for (int i = 0; i < NUM_TAPS; i++)
			add_row($sformatf("ramp_coef_%0d", i), OP_WR_COEF, i, 32'(i + 1), 0, 0);
		add_row("flush_zeros", OP_SEND, 0, 0, NUM_TAPS, 0);
		add_row("impulse_one", OP_SEND, 0, 1, 1, 0);
		add_row("impulse_tail", OP_SEND, 0, 0, NUM_TAPS, 0);
		for (int i = 0; i < NUM_TAPS; i++)
			add_row($sformatf("neg_coef_%0d", i), OP_WR_COEF, i, 32'(-37 * (i + 1)), 0, 0);
		// shifts of 9 or more pull accumulator sign bits into the top of the result
		add_row("shift_twelve", OP_WR_SHIFT, 0, 12, 0, 0);
		add_row("negative_sums", OP_SEND, 0, 1001, NUM_TAPS + 2, 0);
		add_row("shift_random", OP_SEND_RAND, 0, 0, 16, 0);
		add_row("stall_output", OP_STALL, 0, 0, 12, 0);
		add_row("rd_neg_coef", OP_RD_COEF, NUM_TAPS - 1, 0, 0, 32'(-37 * NUM_TAPS));
	endtask

	task automatic run_row(input int i);
		axil_resp_t  resp;
		logic [31:0] data;
		logic [31:0] r;
		case (ops[i])
			OP_WR_COEF:
			begin
				axil_write(COEF_BASE_ADDR + AXIL_ADDR_WIDTH'(4 * addrs[i]), datas[i], resp);
				check_value("bresp", RESP_OKAY, resp);
			end
			OP_WR_SHIFT:
			begin
				axil_write(SHIFT_ADDR, datas[i], resp);
				check_value("bresp", RESP_OKAY, resp);
			end
			OP_BAD_WR:
			begin
				axil_write(AXIL_ADDR_WIDTH'(addrs[i]), datas[i], resp);
				check_value("bresp", RESP_SLVERR, resp);
			end
			OP_RD_COEF:
			begin
				axil_read(COEF_BASE_ADDR + AXIL_ADDR_WIDTH'(4 * addrs[i]), data, resp);
				check_value("rresp", RESP_OKAY, resp);
				check_value("rdata", exp_vals[i], data);
			end
			OP_SEND:
				for (int n = 0; n < counts[i] && !timed_out; n++)
					send_sample(datas[i][DATA_WIDTH-1:0], 0);
			OP_SEND_RAND:
				for (int n = 0; n < counts[i] && !timed_out; n++)
				begin
					r = next_random();
					send_sample(r[DATA_WIDTH-1:0], 0);
				end
			OP_STALL:
				for (int n = 0; n < counts[i] && !timed_out; n++)
				begin
					r = next_random();
					send_sample(r[DATA_WIDTH-1:0], 1 + int'(next_random() % 6));
				end
			default:
				tb_errors++;
		endcase
	endtask

	initial
	begin
		reset     <= 1'b1;
		in_data   <= '0;
		in_valid  <= 1'b0;
		out_ready <= 1'b1;
		awaddr    <= '0;
		awvalid   <= 1'b0;
		wdata     <= '0;
		wstrb     <= '0;
		wvalid    <= 1'b0;
		bready    <= 1'b1;
		araddr    <= '0;
		arvalid   <= 1'b0;
		rready    <= 1'b1;
		build_table();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < names.size() && !timed_out; i++)
		begin
			cur_name = names[i];
			errs_before = tb_errors + error_count;
			fir_checker_inst.begin_test(names[i]);
			run_row(i);
			@(posedge clk);
			tests_run++;
			if (tb_errors + error_count == errs_before)
				$display("test %-16s ok", names[i]);
			else
			begin
				tests_failed++;
				$display("test %-16s FAILED", names[i]);
			end
		end
		if (sent_count != result_count)
		begin
			$display("Lost samples: %0d sent but %0d results taken", sent_count, result_count);
			tb_errors++;
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, tb_errors + error_count);
		if (tb_errors + error_count == 0 && !timed_out)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* bench/fir_checker.sv */
`timescale 1ns/1ps

module fir_checker #(
	parameter int DATA_WIDTH = 16,
	parameter int COEF_WIDTH = 16,
	parameter int NUM_TAPS   = 8
)(
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [DATA_WIDTH-1:0]                 in_data,
	input  logic                                  in_valid,
	input  logic                                  in_ready,
	input  logic [fir_pkg::OUT_WIDTH-1:0]         out_data,
	input  logic                                  out_valid,
	input  logic                                  out_ready,
	input  logic [fir_pkg::AXIL_ADDR_WIDTH-1:0]   awaddr,
	input  logic                                  awvalid,
	input  logic                                  awready,
	input  logic [fir_pkg::AXIL_DATA_WIDTH-1:0]   wdata,
	input  logic [fir_pkg::AXIL_DATA_WIDTH/8-1:0] wstrb,
	input  logic                                  wvalid,
	input  logic                                  wready,
	input  logic [1:0]                            bresp,
	input  logic                                  bvalid,
	input  logic                                  bready,
	input  logic [fir_pkg::AXIL_ADDR_WIDTH-1:0]   araddr,
	input  logic                                  arvalid,
	input  logic                                  arready,
	input  logic [fir_pkg::AXIL_DATA_WIDTH-1:0]   rdata,
	input  logic [1:0]                            rresp,
	input  logic                                  rvalid,
	input  logic                                  rready,
	output int                                    error_count,
	output int                                    result_count
);

	import fir_pkg::*;

	string                        test_name = "none";
	logic signed [DATA_WIDTH-1:0] taps_m [NUM_TAPS];
	logic signed [COEF_WIDTH-1:0] coefs_m [NUM_TAPS];
	int unsigned                  shift_m;
	logic [AXIL_ADDR_WIDTH-1:0]   wr_addr;
	logic [AXIL_DATA_WIDTH-1:0]   wr_data;
	logic [AXIL_DATA_WIDTH/8-1:0] wr_strb;
	bit                           have_aw;
	bit                           have_w;
	logic [31:0]                  exp_out [$];
	longint                       accept_cycle [$];
	logic [1:0]                   exp_bresp [$];
	logic [31:0]                  exp_rdata [$];
	logic [1:0]                   exp_rresp [$];
	longint                       cycle;
	longint                       latency;
	bit                           stalled;
	bit                           prev_valid;
	logic [31:0]                  held_data;
	logic [31:0]                  exp_word;

	task automatic begin_test(input string name);
		test_name = name;
	endtask

	task automatic mismatch(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
		error_count++;
	endtask

	task automatic complain(input string what);
		$display("Error in %s: %s", test_name, what);
		error_count++;
	endtask

	function automatic int coef_slot(input logic [AXIL_ADDR_WIDTH-1:0] addr);
		int off;
		off = int'(addr) - int'(COEF_BASE_ADDR);
		if (addr[1:0] != 2'b00 || off < 0 || off / 4 >= NUM_TAPS)
			return -1;
		return off / 4;
	endfunction

	// dot product of the newest NUM_TAPS samples, arithmetic shift, low 32 bits kept
	function automatic logic [31:0] filter_result();
		longint sum;
		sum = 0;
		for (int i = 0; i < NUM_TAPS; i++)
			sum += longint'(taps_m[i]) * longint'(coefs_m[i]);
		sum = sum >>> shift_m;
		return sum[31:0];
	endfunction

	task automatic apply_write();
		logic [31:0] mask;
		logic [31:0] merged;
		int slot;
		for (int k = 0; k < 4; k++)
			mask[8*k +: 8] = {8{wr_strb[k]}};
		slot = coef_slot(wr_addr);
		if (wr_addr == SHIFT_ADDR)
		begin
			if (wr_strb[0])
				shift_m = wr_data[SHIFT_WIDTH-1:0];
			exp_bresp.push_back(RESP_OKAY);
		end
		else if (slot >= 0)
		begin
			merged = (32'(coefs_m[slot]) & ~mask) | (wr_data & mask);
			coefs_m[slot] = merged[COEF_WIDTH-1:0];
			exp_bresp.push_back(RESP_OKAY);
		end
		else
			exp_bresp.push_back(RESP_SLVERR);
	endtask

	task automatic expect_read();
		int slot;
		slot = coef_slot(araddr);
		if (araddr == SHIFT_ADDR)
		begin
			exp_rdata.push_back(32'(shift_m));
			exp_rresp.push_back(RESP_OKAY);
		end
		else if (slot >= 0)
		begin
			exp_rdata.push_back(32'(coefs_m[slot]));
			exp_rresp.push_back(RESP_OKAY);
		end
		else
		begin
			exp_rdata.push_back('0);
			exp_rresp.push_back(RESP_SLVERR);
		end
	endtask

	// ==================================================
	// port watcher
	// ==================================================
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_TAPS; i++)
			begin
				taps_m[i] = '0;
				coefs_m[i] = '0;
			end
			shift_m = 0;
			have_aw = 0;
			have_w = 0;
			stalled = 0;
			prev_valid = 0;
			cycle = 0;
			error_count = 0;
			result_count = 0;
		end
		else
		begin
			cycle++;
			if (in_valid && in_ready)
			begin
				for (int i = NUM_TAPS - 1; i > 0; i--)
					taps_m[i] = taps_m[i-1];
				taps_m[0] = in_data;
				exp_out.push_back(filter_result());
				accept_cycle.push_back(cycle);
			end
			// out_valid is seen one edge after the edge that raised it
			if (out_valid && !prev_valid)
			begin
				if (accept_cycle.size() == 0)
					complain("out_valid rose with no sample accepted");
				else
				begin
					latency = cycle - 1 - accept_cycle.pop_front();
					if (latency != NUM_TAPS + 1)
						mismatch("latency", 32'(NUM_TAPS + 1), 32'(latency));
				end
			end
			if (stalled)
			begin
				if (!out_valid)
					complain("out_valid dropped while out_ready was low");
				else if (out_data !== held_data)
					mismatch("held out_data", held_data, out_data);
			end
			if (out_valid && in_ready)
				complain("in_ready was high while a result was waiting");
			if (out_valid && out_ready)
			begin
				result_count++;
				if (exp_out.size() == 0)
					complain("a result came out with none expected");
				else
				begin
					exp_word = exp_out.pop_front();
					if (out_data !== exp_word)
						mismatch("out_data", exp_word, out_data);
				end
			end
			stalled = out_valid && !out_ready;
			prev_valid = out_valid;
			held_data = out_data;

			if (awvalid && awready)
			begin
				wr_addr = awaddr;
				have_aw = 1;
			end
			if (wvalid && wready)
			begin
				wr_data = wdata;
				wr_strb = wstrb;
				have_w = 1;
			end
			if (bvalid && bready)
			begin
				if (exp_bresp.size() == 0)
					complain("write response with no write pending");
				else
				begin
					exp_word = 32'(exp_bresp.pop_front());
					if (32'(bresp) !== exp_word)
						mismatch("bresp", exp_word, 32'(bresp));
				end
			end
			if (have_aw && have_w)
			begin
				apply_write();
				have_aw = 0;
				have_w = 0;
			end
			if (arvalid && arready)
				expect_read();
			if (rvalid && rready)
			begin
				if (exp_rdata.size() == 0)
					complain("read data with no read pending");
				else
				begin
					exp_word = exp_rdata.pop_front();
					if (rdata !== exp_word)
						mismatch("rdata", exp_word, rdata);
					exp_word = 32'(exp_rresp.pop_front());
					if (32'(rresp) !== exp_word)
						mismatch("rresp", exp_word, 32'(rresp));
				end
			end
		end
	end

endmodule

/* hdl/fir_filter_top.sv */
`timescale 1ns/1ps

module fir_filter_top #(
	parameter int DATA_WIDTH = 16,
	parameter int COEF_WIDTH = 16,
	parameter int NUM_TAPS   = 8
)(
	input  logic                                  clk,
	input  logic                                  reset,
	// sample stream
	input  logic [DATA_WIDTH-1:0]                 in_data,
	input  logic                                  in_valid,
	output logic                                  in_ready,
	// result stream
	output logic [fir_pkg::OUT_WIDTH-1:0]         out_data,
	output logic                                  out_valid,
	input  logic                                  out_ready,
	// AXI4-Lite register bus
	input  logic [fir_pkg::AXIL_ADDR_WIDTH-1:0]   awaddr,
	input  logic                                  awvalid,
	output logic                                  awready,
	input  logic [fir_pkg::AXIL_DATA_WIDTH-1:0]   wdata,
	input  logic [fir_pkg::AXIL_DATA_WIDTH/8-1:0] wstrb,
	input  logic                                  wvalid,
	output logic                                  wready,
	output fir_pkg::axil_resp_t                   bresp,
	output logic                                  bvalid,
	input  logic                                  bready,
	input  logic [fir_pkg::AXIL_ADDR_WIDTH-1:0]   araddr,
	input  logic                                  arvalid,
	output logic                                  arready,
	output logic [fir_pkg::AXIL_DATA_WIDTH-1:0]   rdata,
	output fir_pkg::axil_resp_t                   rresp,
	output logic                                  rvalid,
	input  logic                                  rready
);

	import fir_pkg::*;

	logic                           shift_en;
	logic [NUM_TAPS*DATA_WIDTH-1:0] taps_flat;
	logic [NUM_TAPS*COEF_WIDTH-1:0] coefs_flat;
	logic [SHIFT_WIDTH-1:0]         shift_amount;

	tap_delay_line #(
		.DATA_WIDTH (DATA_WIDTH),
		.NUM_TAPS   (NUM_TAPS)
	) tap_delay_line_inst (
		.clk       (clk),
		.reset     (reset),
		.shift_en  (shift_en),
		.sample_in (in_data),
		.taps_flat (taps_flat)
	);

	coef_regfile_axil #(
		.COEF_WIDTH (COEF_WIDTH),
		.NUM_TAPS   (NUM_TAPS)
	) coef_regfile_axil_inst (
		.clk          (clk),
		.reset        (reset),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.coefs_flat   (coefs_flat),
		.shift_amount (shift_amount)
	);

	mac_sequencer #(
		.DATA_WIDTH (DATA_WIDTH),
		.COEF_WIDTH (COEF_WIDTH),
		.NUM_TAPS   (NUM_TAPS)
	) mac_sequencer_inst (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.shift_en     (shift_en),
		.taps_flat    (taps_flat),
		.coefs_flat   (coefs_flat),
		.shift_amount (shift_amount),
		.out_data     (out_data),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

endmodule

/* hdl/mac_sequencer.sv */
`timescale 1ns/1ps

module mac_sequencer #(
	parameter int DATA_WIDTH = 16,
	parameter int COEF_WIDTH = 16,
	parameter int NUM_TAPS   = 8
)(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            in_valid,
	output logic                            in_ready,
	output logic                            shift_en,
	input  logic [NUM_TAPS*DATA_WIDTH-1:0]  taps_flat,
	input  logic [NUM_TAPS*COEF_WIDTH-1:0]  coefs_flat,
	input  logic [fir_pkg::SHIFT_WIDTH-1:0] shift_amount,
	output logic [fir_pkg::OUT_WIDTH-1:0]   out_data,
	output logic                            out_valid,
	input  logic                            out_ready
);

	import fir_pkg::*;

	localparam int CNT_W  = $clog2(NUM_TAPS + 1);
	localparam int SEL_W  = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;
	localparam int PROD_W = DATA_WIDTH + COEF_WIDTH;

	mac_state_t                   state;
	logic [CNT_W-1:0]             count;
	logic                         last_step;
	logic [SEL_W-1:0]             sel;
	logic signed [DATA_WIDTH-1:0] tap_cur;
	logic signed [COEF_WIDTH-1:0] coef_cur;
	logic signed [PROD_W-1:0]     product;
	logic signed [ACC_WIDTH-1:0]  acc;
	logic signed [ACC_WIDTH-1:0]  acc_shifted;
	logic [OUT_WIDTH-1:0]         result_q;

	// count runs 0..NUM_TAPS-1 for the products, NUM_TAPS is the output step
	assign last_step = (count == CNT_W'(NUM_TAPS));
	assign sel       = last_step ? '0 : count[SEL_W-1:0];

	assign tap_cur     = taps_flat[sel*DATA_WIDTH +: DATA_WIDTH];
	assign coef_cur    = coefs_flat[sel*COEF_WIDTH +: COEF_WIDTH];
	assign product     = tap_cur * coef_cur;
	assign acc_shifted = acc >>> shift_amount;

	assign in_ready  = (state == MAC_IDLE);
	assign shift_en  = in_valid && in_ready;
	assign out_valid = (state == MAC_HOLD);
	assign out_data  = result_q;

	// ==================================================
	// control
	// ==================================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= MAC_IDLE;
			count <= '0;
		end
		else
		begin
			case (state)
				MAC_IDLE:
				begin
					if (in_valid)
					begin
						state <= MAC_ACCUM;
						count <= '0;
					end
				end
				MAC_ACCUM:
				begin
					if (last_step)
						state <= MAC_HOLD;
					else
						count <= count + 1'b1;
				end
				MAC_HOLD:
				begin
					// stalled downstream keeps the result
					if (out_ready)
						state <= MAC_IDLE;
				end
				default:
					state <= MAC_IDLE;
			endcase
		end
	end

	// accumulator and result
	always_ff @(posedge clk)
	begin
		if (shift_en)
			acc <= '0;
		else if (state == MAC_ACCUM && !last_step)
			acc <= acc + ACC_WIDTH'(product);
		if (state == MAC_ACCUM && last_step)
			result_q <= acc_shifted[OUT_WIDTH-1:0];
	end

	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

	// delay line holds still through the accumulation and the hold
	a_shift_idle: assert property (@(posedge clk) disable iff (reset)
		state != MAC_IDLE |=> $stable(taps_flat));

endmodule

/* hdl/coef_regfile_axil.sv */
`timescale 1ns/1ps

module coef_regfile_axil #(
	parameter int COEF_WIDTH = 16,
	parameter int NUM_TAPS   = 8
)(
	input  logic                                 clk,
	input  logic                                 reset,
	// write address
	input  logic [fir_pkg::AXIL_ADDR_WIDTH-1:0]  awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	// write data
	input  logic [fir_pkg::AXIL_DATA_WIDTH-1:0]  wdata,
	input  logic [fir_pkg::AXIL_DATA_WIDTH/8-1:0] wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	// write response
	output fir_pkg::axil_resp_t                  bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	// read address
	input  logic [fir_pkg::AXIL_ADDR_WIDTH-1:0]  araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	// read data
	output logic [fir_pkg::AXIL_DATA_WIDTH-1:0]  rdata,
	output fir_pkg::axil_resp_t                  rresp,
	output logic                                 rvalid,
	input  logic                                 rready,
	// to the datapath
	output logic [NUM_TAPS*COEF_WIDTH-1:0]       coefs_flat,
	output logic [fir_pkg::SHIFT_WIDTH-1:0]      shift_amount
);

	import fir_pkg::*;

	localparam int IDX_W = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;

	logic [COEF_WIDTH-1:0]        coefs [NUM_TAPS];
	logic [SHIFT_WIDTH-1:0]       shift_q;

	logic                         aw_full;
	logic                         w_full;
	logic                         ar_full;
	logic [AXIL_ADDR_WIDTH-1:0]   aw_addr_q;
	logic [AXIL_DATA_WIDTH-1:0]   w_data_q;
	logic [AXIL_DATA_WIDTH/8-1:0] w_strb_q;
	logic [AXIL_ADDR_WIDTH-1:0]   ar_addr_q;

	logic                         wr_go;
	logic                         rd_go;
	logic                         w_is_coef;
	logic                         r_is_coef;
	logic [IDX_W-1:0]             w_idx;
	logic [IDX_W-1:0]             r_idx;

	// aligned, inside the coefficient window, not the shift register
	function automatic logic coef_hit(input logic [AXIL_ADDR_WIDTH-1:0] addr);
		logic [AXIL_ADDR_WIDTH-1:0] off;
		off = addr - COEF_BASE_ADDR;
		return (addr[1:0] == 2'b00) && ((off >> 2) < AXIL_ADDR_WIDTH'(NUM_TAPS))
			&& (addr != SHIFT_ADDR);
	endfunction

	function automatic logic [IDX_W-1:0] coef_index(input logic [AXIL_ADDR_WIDTH-1:0] addr);
		logic [AXIL_ADDR_WIDTH-1:0] off;
		off = addr - COEF_BASE_ADDR;
		return off[IDX_W+1:2];
	endfunction

	assign w_is_coef = coef_hit(aw_addr_q);
	assign r_is_coef = coef_hit(ar_addr_q);
	assign w_idx     = coef_index(aw_addr_q);
	assign r_idx     = coef_index(ar_addr_q);

	assign awready = !aw_full && !bvalid;
	assign wready  = !w_full && !bvalid;
	assign arready = !ar_full && !rvalid;

	// commit one cycle after both halves are in
	assign wr_go = aw_full && w_full && !bvalid;
	assign rd_go = ar_full && !rvalid;

	// ==================================================
	// channel latches
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (awvalid && awready)
			aw_addr_q <= awaddr;
		if (wvalid && wready)
		begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
		if (arvalid && arready)
			ar_addr_q <= araddr;
	end

	// ==================================================
	// write path
	// ==================================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			aw_full <= 1'b0;
			w_full  <= 1'b0;
			bvalid  <= 1'b0;
			shift_q <= '0;
			for (int i = 0; i < NUM_TAPS; i++)
			begin
				coefs[i] <= '0;
			end
		end
		else
		begin
			if (awvalid && awready)
				aw_full <= 1'b1;
			if (wvalid && wready)
				w_full <= 1'b1;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_go)
			begin
				aw_full <= 1'b0;
				w_full  <= 1'b0;
				bvalid  <= 1'b1;
				if (aw_addr_q == SHIFT_ADDR)
				begin
					if (w_strb_q[0])
						shift_q <= w_data_q[SHIFT_WIDTH-1:0];
				end
				else if (w_is_coef)
				begin
					for (int b = 0; b < COEF_WIDTH; b++)
					begin
						if (w_strb_q[b/8])
							coefs[w_idx][b] <= w_data_q[b];
					end
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_go)
			bresp <= (aw_addr_q == SHIFT_ADDR || w_is_coef) ? RESP_OKAY : RESP_SLVERR;
	end

	// ==================================================
	// read path
	// ==================================================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ar_full <= 1'b0;
			rvalid  <= 1'b0;
		end
		else
		begin
			if (arvalid && arready)
				ar_full <= 1'b1;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_go)
			begin
				ar_full <= 1'b0;
				rvalid  <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_go)
		begin
			if (ar_addr_q == SHIFT_ADDR)
			begin
				rdata <= AXIL_DATA_WIDTH'(shift_q);
				rresp <= RESP_OKAY;
			end
			else if (r_is_coef)
			begin
				// coefficients read back sign-extended
				rdata <= AXIL_DATA_WIDTH'($signed(coefs[r_idx]));
				rresp <= RESP_OKAY;
			end
			else
			begin
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end
		end
	end

	for (genvar g = 0; g < NUM_TAPS; g++)
	begin : g_coef
		assign coefs_flat[g*COEF_WIDTH +: COEF_WIDTH] = coefs[g];
	end

	assign shift_amount = shift_q;

	a_b_held: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));

	a_r_held: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* hdl/tap_delay_line.sv */
`timescale 1ns/1ps

module tap_delay_line #(
	parameter int DATA_WIDTH = 16,
	parameter int NUM_TAPS   = 8
)(
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           shift_en,
	input  logic [DATA_WIDTH-1:0]          sample_in,
	output logic [NUM_TAPS*DATA_WIDTH-1:0] taps_flat
);

	// tap 0 holds the newest sample, tap NUM_TAPS-1 the oldest
	logic [DATA_WIDTH-1:0] taps [NUM_TAPS];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_TAPS; i++)
			begin
				taps[i] <= '0;
			end
		end
		else if (shift_en)
		begin
			taps[0] <= sample_in;
			for (int i = 1; i < NUM_TAPS; i++)
			begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// every stage visible at once
	for (genvar g = 0; g < NUM_TAPS; g++)
	begin : g_flat
		assign taps_flat[g*DATA_WIDTH +: DATA_WIDTH] = taps[g];
	end

endmodule

/* hdl/fir_pkg.sv */
package fir_pkg;

	// ==================================================
	// sequencer states
	// ==================================================
	typedef enum logic [1:0]
	{
		MAC_IDLE  = 2'd0,
		MAC_ACCUM = 2'd1,
		MAC_HOLD  = 2'd2
	} mac_state_t;

	// AXI response codes, only the two the slave returns
	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_t;

	// ==================================================
	// widths and address map
	// ==================================================
	localparam int AXIL_ADDR_WIDTH = 12;
	localparam int AXIL_DATA_WIDTH = 32;
	localparam int ACC_WIDTH       = 40;
	localparam int OUT_WIDTH       = 32;
	localparam int SHIFT_WIDTH     = 6;

	// coefficient i at COEF_BASE_ADDR + 4*i, window tops out at 64 taps
	localparam logic [AXIL_ADDR_WIDTH-1:0] COEF_BASE_ADDR = 12'h000;
	localparam logic [AXIL_ADDR_WIDTH-1:0] SHIFT_ADDR     = 12'h100;

endpackage
